/* common/cart_cfg.svh */
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

//////////////////////////////
// timing constants
//////////////////////////////

// delay cycles an mcu access holds the psram
`define CART_ROM_CYCLE_LEN 7

// clk2 cycles with cpu clock low before console counts as dead
`define CART_DEAD_TIMEOUT 96000

// stages on snes address and data lines
`define CART_ADDR_DELAY 7

//////////////////////////////
// memory layout
//////////////////////////////

// save ram lives above the rom image in psram
`define CART_SAVERAM_BASE 24'he00000

`endif

/* common/snes_bus_pkg.sv */
package snes_bus_pkg;

  // full 24-bit cpu address, bank in 23:16
  typedef logic [23:0] snes_addr_t;

  typedef logic [7:0] byte_t;

  // bus as seen after sampling and filtering
  typedef struct packed {
    snes_addr_t addr;
    byte_t      data;
    // active low strobes
    logic       rd_n;
    logic       wr_n;
    // high during the data phase of a cpu cycle
    logic       cpu_clk;
  } snes_bus_t;

  // single-cycle strobes from the control line history
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    // rising edge of cpu clock
    logic cycle_start;
    // falling edge of cpu clock
    logic cycle_end;
  } snes_evt_t;

endpackage

/* common/psram_pkg.sv */
package psram_pkg;

  // byte address, bit 0 picks the lane
  typedef logic [23:0] psram_addr_t;

  // size masks from the mcu
  typedef struct packed {
    psram_addr_t rom_mask;
    psram_addr_t saveram_mask;
  } map_cfg_t;

  // decode result for the current snes address
  typedef struct packed {
    psram_addr_t addr;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
  } map_hit_t;

  // rrq and wrq are one-cycle pulses
  typedef struct packed {
    psram_addr_t addr;
    logic [7:0]  wdata;
    logic        rrq;
    logic        wrq;
  } mcu_req_t;

  // mcu side of the psram, active while the fsm owns the memory
  typedef struct packed {
    logic        active;
    logic        write;
    psram_addr_t addr;
    logic [7:0]  wdata;
  } mcu_port_t;

  // one-hot access fsm
  typedef enum logic [4:0] {
    st_idle    = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end  = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end  = 5'b10000
  } access_state_e;

endpackage

/* hdl/snes_bus_sync.sv */
`timescale 1ns/1ps
`include "cart_cfg.svh"

module snes_bus_sync import snes_bus_pkg::*; (
  input  logic       CLK2,
  input  logic       rst,
  input  snes_addr_t snes_addr_in,
  input  byte_t      snes_data_in,
  input  logic       snes_rd_n_in,
  input  logic       snes_wr_n_in,
  input  logic       snes_cpu_clk_in,
  output snes_bus_t  bus,
  output snes_evt_t  evt,
  output logic       snes_dead
);

  localparam int DEAD_W = $clog2(`CART_DEAD_TIMEOUT + 1);

  // sample histories with bit 0 newest
  logic [7:0] rd_hist;
  logic [7:0] wr_hist;
  logic [7:0] clk_hist;
  // filtered and registered controls
  logic rd_n_q;
  logic wr_n_q;
  logic cpu_clk_q;
  snes_addr_t addr_dly [`CART_ADDR_DELAY];
  byte_t data_dly [`CART_ADDR_DELAY];
  logic [DEAD_W-1:0] dead_cnt;

  //////////////////////////////
  // control line sampling
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      // idle bus has strobes high and cpu clock low
      rd_hist   <= '1;
      wr_hist   <= '1;
      clk_hist  <= '0;
      rd_n_q    <= 1'b1;
      wr_n_q    <= 1'b1;
      cpu_clk_q <= 1'b0;
    end else begin
      rd_hist  <= {rd_hist[6:0], snes_rd_n_in};
      wr_hist  <= {wr_hist[6:0], snes_wr_n_in};
      clk_hist <= {clk_hist[6:0], snes_cpu_clk_in};
      // two-sample filter then register
      rd_n_q    <= rd_hist[1] & rd_hist[0];
      wr_n_q    <= wr_hist[1] & wr_hist[0];
      cpu_clk_q <= clk_hist[1] & clk_hist[0];
    end
  end

  // address and data lag the strobes
  always_ff @(posedge CLK2) begin
    addr_dly[0] <= snes_addr_in;
    data_dly[0] <= snes_data_in;
    for (int i = 1; i < `CART_ADDR_DELAY; i++) begin
      addr_dly[i] <= addr_dly[i-1];
      data_dly[i] <= data_dly[i-1];
    end
  end

  assign bus = '{
    addr:    addr_dly[`CART_ADDR_DELAY-1],
    data:    data_dly[`CART_ADDR_DELAY-1],
    rd_n:    rd_n_q,
    wr_n:    wr_n_q,
    cpu_clk: cpu_clk_q
  };

  //////////////////////////////
  // edge events
  //////////////////////////////

  // read start needs a settled low after a settled high
  assign evt.rd_start    = ((rd_hist[6:1] | rd_hist[7:2]) == 6'b111100);
  // strobe ends react on the first clean high
  assign evt.rd_end      = (rd_hist[3:1] == 3'b011);
  assign evt.wr_end      = (wr_hist[3:1] == 3'b011);
  assign evt.cycle_start = ((clk_hist[7:2] & clk_hist[6:1]) == 6'b000011);
  assign evt.cycle_end   = ((clk_hist[7:2] | clk_hist[6:1]) == 6'b111000);

  //////////////////////////////
  // dead console detect
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (clk_hist[1]) begin
      // any cpu clock high revives the console
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (dead_cnt != DEAD_W'(`CART_DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end else begin
      // counter parks at the limit
      snes_dead <= 1'b1;
    end
  end

  // the cpu never reads and writes in the same cycle
  a_rd_wr_excl: assert property (@(posedge CLK2) disable iff (rst)
    (rd_n_q || wr_n_q));

endmodule

/* hdl/cart_map.sv */
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_map
  import snes_bus_pkg::*;
  import psram_pkg::*;
(
  input  snes_bus_t bus,
  input  map_cfg_t  cfg,
  output map_hit_t  hit
);

  logic [7:0] bank;
  // banks 70..7d hold save ram below 8000
  logic sram_bank;
  // 7e/7f are console wram and never ours
  logic wram_bank;
  logic is_rom;
  logic is_saveram;
  psram_addr_t rom_addr;
  psram_addr_t sram_addr;

  //////////////////////////////
  // lorom decode
  //////////////////////////////

  assign bank      = bus.addr[23:16];
  assign sram_bank = (bank >= 8'h70) && (bank <= 8'h7d);
  assign wram_bank = (bank[7:1] == 7'b0111111);

  assign is_saveram = sram_bank & ~bus.addr[15];
  assign is_rom     = bus.addr[15] & ~sram_bank & ~wram_bank;

  // 32k pages packed back to back and mirrored by the rom mask
  assign rom_addr = psram_addr_t'({bank[6:0], bus.addr[14:0]}) & cfg.rom_mask;

  // save ram window above the rom image
  assign sram_addr = psram_addr_t'(`CART_SAVERAM_BASE) + (bus.addr & cfg.saveram_mask);

  assign hit = '{
    addr:        is_saveram ? sram_addr : rom_addr,
    is_rom:      is_rom,
    is_saveram:  is_saveram,
    // only save ram takes snes writes
    is_writable: is_saveram
  };

endmodule

/* hdl/mcu_access.sv */
`timescale 1ns/1ps
`include "cart_cfg.svh"

module mcu_access
  import snes_bus_pkg::*;
  import psram_pkg::*;
(
  input  logic      CLK2,
  input  logic      rst,
  input  mcu_req_t  req,
  input  snes_evt_t evt,
  input  logic      snes_dead,
  input  logic      rom_hit,
  input  byte_t     rd_byte,
  output mcu_port_t port,
  output logic      rdy,
  output byte_t     mcu_rdata
);

  localparam int DLY_W = $clog2(`CART_ROM_CYCLE_LEN + 1);

  access_state_e state;
  logic [DLY_W-1:0] dly;
  logic rd_pend;
  logic wr_pend;
  psram_addr_t addr_q;
  logic [7:0] wdata_q;
  // cycle after a non-rom cycle start
  logic free_strobe;
  logic free_slot;
  logic dead_q;
  logic revived;

  //////////////////////////////
  // request latch
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (state == st_rd_end || state == st_wr_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rrq || req.wrq) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
  end

  //////////////////////////////
  // slot detect
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
      dead_q      <= 1'b1;
    end else begin
      free_strobe <= evt.cycle_start & ~rom_hit;
      dead_q      <= snes_dead;
    end
  end

  assign free_slot = evt.cycle_end | free_strobe;
  // console just woke, abort and retry
  assign revived = dead_q & ~snes_dead;

  //////////////////////////////
  // access fsm
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state <= st_idle;
      dly   <= '0;
    end else if (revived) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // dead console means every cycle is free
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state <= st_rd_addr;
              dly   <= DLY_W'(`CART_ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state <= st_wr_addr;
              dly   <= DLY_W'(`CART_ROM_CYCLE_LEN);
            end
          end
        end
        st_rd_addr, st_wr_addr: begin
          dly <= dly - 1'b1;
          if (dly == '0) begin
            state <= (state == st_rd_addr) ? st_rd_end : st_wr_end;
          end
        end
        // end states return to idle
        default: state <= st_idle;
      endcase
    end
  end

  // last sample before rd_end is the settled one
  always_ff @(posedge CLK2) begin
    if (state == st_rd_addr) begin
      mcu_rdata <= rd_byte;
    end
  end

  assign port = '{
    active: (state == st_rd_addr) || (state == st_wr_addr),
    write:  (state == st_wr_addr),
    addr:   addr_q,
    wdata:  wdata_q
  };

  // mcu waits for rdy before the next request
  a_req_rdy: assert property (@(posedge CLK2) disable iff (rst)
    (req.rrq || req.wrq) |-> rdy);

endmodule

/* hdl/psram_mux.sv */
`timescale 1ns/1ps

module psram_mux
  import snes_bus_pkg::*;
  import psram_pkg::*;
(
  input  snes_bus_t   bus,
  input  map_hit_t    hit,
  input  mcu_port_t   port,
  input  logic [15:0] psram_rdata,
  output logic [22:0] psram_addr,
  output logic        psram_ble_n,
  output logic        psram_bhe_n,
  output logic        psram_we_n,
  output logic [15:0] psram_wdata,
  output logic        psram_data_oe,
  output byte_t       rd_byte,
  output byte_t       snes_data_out,
  output logic        snes_databus_oe_n,
  output logic        snes_databus_dir
);

  psram_addr_t addr_sel;
  // set selects bits 7:0
  logic lane_lo;
  logic mcu_wr;
  logic snes_wr;
  byte_t wbyte;

  //////////////////////////////
  // address and lanes
  //////////////////////////////

  // mcu owns the memory while active
  assign addr_sel = port.active ? port.addr : hit.addr;
  assign lane_lo  = addr_sel[0];

  assign psram_addr  = addr_sel[23:1];
  assign psram_ble_n = ~lane_lo;
  assign psram_bhe_n = lane_lo;

  //////////////////////////////
  // writes
  //////////////////////////////

  assign mcu_wr = port.active & port.write;
  // snes write only in the data phase
  assign snes_wr = ~port.active & hit.is_writable & bus.cpu_clk & ~bus.wr_n;

  assign wbyte = port.active ? port.wdata : bus.data;

  assign psram_we_n    = ~(mcu_wr | snes_wr);
  assign psram_data_oe = mcu_wr | snes_wr;
  // other lane is masked by its byte enable
  assign psram_wdata = lane_lo ? {8'h00, wbyte} : {wbyte, 8'h00};

  //////////////////////////////
  // reads and snes bus drive
  //////////////////////////////

  assign rd_byte       = lane_lo ? psram_rdata[7:0] : psram_rdata[15:8];
  assign snes_data_out = rd_byte;

  // level shifter points at the snes while it reads
  assign snes_databus_dir = ~bus.rd_n;
  // off for unmapped space or an idle bus
  assign snes_databus_oe_n = (~hit.is_rom & ~hit.is_saveram) | (bus.rd_n & bus.wr_n);

endmodule

/* hdl/cart_top.sv */
`timescale 1ns/1ps

module cart_top
  import snes_bus_pkg::*;
  import psram_pkg::*;
(
  input  logic        CLK2,
  input  logic        rst,
  // snes cartridge edge
  input  snes_addr_t  snes_addr_in,
  input  byte_t       snes_data_in,
  input  logic        snes_rd_n_in,
  input  logic        snes_wr_n_in,
  input  logic        snes_cpu_clk_in,
  output byte_t       snes_data_out,
  output logic        snes_databus_oe_n,
  output logic        snes_databus_dir,
  // mcu side
  input  map_cfg_t    map_cfg,
  input  mcu_req_t    mcu_req,
  output logic        mcu_rdy,
  output byte_t       mcu_rdata,
  // psram pins
  output logic [22:0] psram_addr,
  output logic        psram_ble_n,
  output logic        psram_bhe_n,
  output logic        psram_we_n,
  output logic [15:0] psram_wdata,
  output logic        psram_data_oe,
  input  logic [15:0] psram_rdata
);

  snes_bus_t bus;
  snes_evt_t evt;
  logic snes_dead;
  map_hit_t hit;
  mcu_port_t port;
  byte_t rd_byte;

  snes_bus_sync sync_i (
    .CLK2            (CLK2),
    .rst             (rst),
    .snes_addr_in    (snes_addr_in),
    .snes_data_in    (snes_data_in),
    .snes_rd_n_in    (snes_rd_n_in),
    .snes_wr_n_in    (snes_wr_n_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus),
    .evt             (evt),
    .snes_dead       (snes_dead)
  );

  cart_map map_i (
    .bus (bus),
    .cfg (map_cfg),
    .hit (hit)
  );

  mcu_access mcu_i (
    .CLK2      (CLK2),
    .rst       (rst),
    .req       (mcu_req),
    .evt       (evt),
    .snes_dead (snes_dead),
    .rom_hit   (hit.is_rom),
    .rd_byte   (rd_byte),
    .port      (port),
    .rdy       (mcu_rdy),
    .mcu_rdata (mcu_rdata)
  );

  psram_mux mux_i (
    .bus               (bus),
    .hit               (hit),
    .port              (port),
    .psram_rdata       (psram_rdata),
    .psram_addr        (psram_addr),
    .psram_ble_n       (psram_ble_n),
    .psram_bhe_n       (psram_bhe_n),
    .psram_we_n        (psram_we_n),
    .psram_wdata       (psram_wdata),
    .psram_data_oe     (psram_data_oe),
    .rd_byte           (rd_byte),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic CLK2,
  output logic rst
);

  // 100 ns period
  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  // reset held over the first 16 rising edges
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge CLK2);
    rst <= 1'b0;
  end

endmodule

/* verif/cart_tb.sv */
`timescale 1ns/1ps
`include "cart_cfg.svh"

module cart_tb
  import snes_bus_pkg::*;
  import psram_pkg::*;
();

  // six tests each budgeted past the dead timeout
  localparam int TIMEOUT_CYCLES = 6 * 200000;

  logic CLK2;
  logic rst;
  // dut inputs
  snes_addr_t  snes_addr_in;
  byte_t       snes_data_in;
  logic        snes_rd_n_in;
  logic        snes_wr_n_in;
  logic        snes_cpu_clk_in;
  map_cfg_t    map_cfg;
  mcu_req_t    mcu_req;
  logic [15:0] psram_rdata;
  // dut outputs
  byte_t       snes_data_out;
  logic        snes_databus_oe_n;
  logic        snes_databus_dir;
  logic        mcu_rdy;
  byte_t       mcu_rdata;
  logic [22:0] psram_addr;
  logic        psram_ble_n;
  logic        psram_bhe_n;
  logic        psram_we_n;
  logic [15:0] psram_wdata;
  logic        psram_data_oe;

  // psram model of 64k words plus a preload port
  logic [15:0] psram_mem [65536];
  logic        load_en;
  logic [15:0] load_idx;
  logic [15:0] load_val;

  logic [31:0] lfsr_state;
  // free-running snes cpu clock with 8 clk2 cycles per period
  logic        cpu_run;
  logic [2:0]  cpu_phase;
  int          cycle_cnt = 0;

  tb_clk_gen clk_i (
    .CLK2 (CLK2),
    .rst  (rst)
  );

  cart_top dut_i (
    .CLK2              (CLK2),
    .rst               (rst),
    .snes_addr_in      (snes_addr_in),
    .snes_data_in      (snes_data_in),
    .snes_rd_n_in      (snes_rd_n_in),
    .snes_wr_n_in      (snes_wr_n_in),
    .snes_cpu_clk_in   (snes_cpu_clk_in),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir),
    .map_cfg           (map_cfg),
    .mcu_req           (mcu_req),
    .mcu_rdy           (mcu_rdy),
    .mcu_rdata         (mcu_rdata),
    .psram_addr        (psram_addr),
    .psram_ble_n       (psram_ble_n),
    .psram_bhe_n       (psram_bhe_n),
    .psram_we_n        (psram_we_n),
    .psram_wdata       (psram_wdata),
    .psram_data_oe     (psram_data_oe),
    .psram_rdata       (psram_rdata)
  );

  //////////////////////////////
  // psram model
  //////////////////////////////

  // async read on the low address bits
  assign psram_rdata = psram_mem[psram_addr[15:0]];

  always @(posedge CLK2) begin
    if (load_en) begin
      psram_mem[load_idx] <= load_val;
    end else if (!psram_we_n) begin
      // byte enables pick the lanes
      if (!psram_ble_n) psram_mem[psram_addr[15:0]][7:0] <= psram_wdata[7:0];
      if (!psram_bhe_n) psram_mem[psram_addr[15:0]][15:8] <= psram_wdata[15:8];
    end
  end

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input psram_addr_t got, input psram_addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic byte_t rand_byte();
    byte_t b;
    b = '0;
    repeat (8) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [15:0] w;
    w[15:8] = rand_byte();
    w[7:0]  = rand_byte();
    return w;
  endfunction

  // odd byte address lives on the low lane
  function automatic byte_t lane_of(input psram_addr_t a, input logic [15:0] w);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic tick();
    @(posedge CLK2);
    if (cpu_run) begin
      cpu_phase = cpu_phase + 3'd1;
      snes_cpu_clk_in <= cpu_phase[2];
    end
  endtask

  task automatic ticks(input int n);
    repeat (n) tick();
  endtask

  task automatic preload(input psram_addr_t a, input logic [15:0] w);
    tick();
    load_en  <= 1'b1;
    load_idx <= a[16:1];
    load_val <= w;
    tick();
    load_en  <= 1'b0;
  endtask

  // one-cycle request pulse then wait for rdy
  task automatic mcu_transfer(input psram_addr_t a, input byte_t wd, input logic write);
    tick();
    mcu_req <= '{addr: a, wdata: wd, rrq: ~write, wrq: write};
    tick();
    mcu_req.rrq <= 1'b0;
    mcu_req.wrq <= 1'b0;
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    while (!mcu_rdy) begin
      tick();
      @(negedge CLK2);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic mcu_write_while_dead();
    psram_addr_t a;
    logic [15:0] old;
    byte_t wd;
    a   = 24'h000a41;
    old = rand_word();
    wd  = rand_byte();
    preload(a, old);
    mcu_transfer(a, wd, 1'b1);
    check_byte("psram_mem low lane", psram_mem[a[16:1]][7:0], wd);
    check_byte("psram_mem high lane", psram_mem[a[16:1]][15:8], old[15:8]);
  endtask

  task automatic mcu_read_while_dead();
    psram_addr_t a;
    logic [15:0] w;
    a = 24'h001236;
    w = rand_word();
    preload(a, w);
    mcu_transfer(a, 8'h00, 1'b0);
    check_byte("mcu_rdata", mcu_rdata, lane_of(a, w));
  endtask

  task automatic rom_read();
    snes_addr_t a;
    psram_addr_t exp;
    logic [15:0] w;
    a   = 24'h03c567;
    // bank 03 page offset 4567 sits at 3 * 8000 + 4567
    exp = 24'h01c567;
    w   = rand_word();
    preload(exp, w);
    // wake the console
    cpu_run = 1'b1;
    ticks(16);
    tick();
    snes_addr_in <= a;
    snes_rd_n_in <= 1'b0;
    ticks(20);
    @(negedge CLK2);
    check_addr("psram_addr", psram_addr_t'(psram_addr), exp >> 1);
    check_byte("snes_data_out", snes_data_out, lane_of(exp, w));
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b0);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b1);
    tick();
    snes_rd_n_in <= 1'b1;
    ticks(4);
  endtask

  task automatic saveram_write();
    snes_addr_t a;
    psram_addr_t exp;
    byte_t d;
    a   = 24'h701234;
    // offset 1234 is inside the 8k save ram mask
    exp = `CART_SAVERAM_BASE + 24'h001234;
    d   = rand_byte();
    cpu_run = 1'b0;
    tick();
    snes_cpu_clk_in <= 1'b1;
    snes_addr_in    <= a;
    snes_data_in    <= d;
    // let address and data through the delay line
    ticks(10);
    tick();
    snes_wr_n_in <= 1'b0;
    ticks(6);
    @(negedge CLK2);
    check_bit("psram_we_n", psram_we_n, 1'b0);
    check_bit("psram_data_oe", psram_data_oe, 1'b1);
    tick();
    snes_wr_n_in <= 1'b1;
    ticks(6);
    @(negedge CLK2);
    check_byte("saveram byte", lane_of(exp, psram_mem[exp[16:1]]), d);
  endtask

  task automatic unmapped_read();
    tick();
    // wram bank is not on the cartridge
    snes_addr_in <= 24'h7e8000;
    snes_rd_n_in <= 1'b0;
    ticks(10);
    @(negedge CLK2);
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
    tick();
    snes_rd_n_in <= 1'b1;
    ticks(4);
  endtask

  task automatic mcu_read_while_alive();
    psram_addr_t a;
    logic [15:0] w;
    a = 24'h004a07;
    w = rand_word();
    cpu_run = 1'b1;
    preload(a, w);
    ticks(16);
    // slot wait depends on the cpu clock phase
    mcu_transfer(a, 8'h00, 1'b0);
    check_byte("mcu_rdata", mcu_rdata, lane_of(a, w));
  endtask

  initial begin
    snes_addr_in    = '0;
    snes_data_in    = '0;
    snes_rd_n_in    = 1'b1;
    snes_wr_n_in    = 1'b1;
    snes_cpu_clk_in = 1'b0;
    map_cfg         = '{rom_mask: 24'h3fffff, saveram_mask: 24'h001fff};
    mcu_req         = '0;
    load_en         = 1'b0;
    load_idx        = '0;
    load_val        = '0;
    lfsr_state      = 32'hd1b5;
    cpu_run         = 1'b0;
    cpu_phase       = '0;
    @(negedge rst);
    ticks(2);
    mcu_write_while_dead();
    mcu_read_while_dead();
    rom_read();
    saveram_write();
    unmapped_read();
    mcu_read_while_alive();
    $display("sim passed");
    $finish;
  end

endmodule

/* cart.f */
+incdir+common
common/snes_bus_pkg.sv
common/psram_pkg.sv
hdl/snes_bus_sync.sv
hdl/cart_map.sv
hdl/mcu_access.sv
hdl/psram_mux.sv
hdl/cart_top.sv
verif/tb_clk_gen.sv
verif/cart_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f cart.f --top-module cart_tb -o cart_sim &&
./obj_dir/cart_sim || exit 1
